//--- fifo_display_top.f
design/fifo_demo_pkg.sv
design/fifo_debug_if.sv
design/tick_gen.sv
design/key_sampler.sv
design/pattern_source.sv
design/debug_fifo.sv
design/seven_segment_mux.sv
design/fifo_display_top.sv
testbench/fifo_display_sva.sv
testbench/tb_fifo_display.sv

//--- Makefile
# Verilator build and run of tb_fifo_display

SOURCES := $(shell cat fifo_display_top.f)

obj_dir/Vtb_fifo_display: fifo_display_top.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/100ps \
		--top-module tb_fifo_display -f fifo_display_top.f

run: obj_dir/Vtb_fifo_display
	obj_dir/Vtb_fifo_display +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- testbench/tb_fifo_display.sv
// display checks use the model state one cycle old, as the scan registers its segments
module tb_fifo_display
    import fifo_demo_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // DUT, clock and reference tables
    // ------------------------------------------------------------------------

    logic       clk;
    logic       reset;
    logic [1:0] key;
    logic [7:0] led;
    segments_t  abcdefgh;
    slot_mask_t digit;

    fifo_display_top i_fifo_display_top
    (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // abcdefgh hex glyphs with the dot dark
    localparam segments_t glyph_table [16] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010,
        8'b0110_0110, 8'b1011_0110, 8'b1011_1110, 8'b1110_0000,
        8'b1111_1110, 8'b1110_0110, 8'b1110_1110, 8'b0011_1110,
        8'b1001_1100, 8'b0111_1010, 8'b1001_1110, 8'b1000_1110
    };
    // middle bar alone
    localparam segments_t empty_bar = 8'b0000_0010;

    // values the DUT must store, in push order
    localparam fifo_data_t expected_pattern [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // FIFO model, driven only by what led shows
    fifo_data_t     model_data [fifo_depth];
    slot_mask_t     model_valid;
    fifo_ptr_t      model_wr;
    fifo_ptr_t      model_rd;
    fifo_count_t    model_count;
    pattern_index_t model_index;
    fifo_data_t     last_head;
    int             pop_total;

    // scan tracking
    slot_mask_t last_digit;
    int         held;
    bit         scan_locked;
    bit         checking;

    int     display_errors;
    int     scan_errors;
    int     led_errors;
    int     timeout_errors;
    integer seed;

    // ------------------------------------------------------------------------
    // model and reference
    // ------------------------------------------------------------------------

    // expected segments for a one-hot digit where digit k mirrors slot 7 - k
    function automatic segments_t expected_segments(input slot_mask_t digit_onehot);
        fifo_ptr_t slot;
        segments_t glyph;
        bit        found;
        slot  = '0;
        found = 1'b0;
        for (int k = 0; k < fifo_depth; k++)
        begin
            if (digit_onehot[k])
            begin
                slot  = fifo_ptr_t'(fifo_depth - 1 - k);
                found = 1'b1;
            end
        end
        if (!found)
            return 8'h00;
        glyph = model_valid[slot] ? glyph_table[model_data[slot]] : empty_bar;
        // either pointer lights the dot
        if (slot == model_wr || slot == model_rd)
            glyph[0] = 1'b1;
        return glyph;
    endfunction

    task automatic clear_model();
        for (int k = 0; k < fifo_depth; k++)
            model_data[k] = 4'h0;
        model_valid = '0;
        model_wr    = '0;
        model_rd    = '0;
        model_count = '0;
        model_index = '0;
        last_head   = led[7:4];
        last_digit  = digit;
        held        = 0;
        scan_locked = 1'b0;
    endtask

    task automatic store_entry();
        model_data[model_wr]  = expected_pattern[model_index];
        model_valid[model_wr] = 1'b1;
        model_wr              = model_wr + 1'b1;
        model_index           = model_index + 1'b1;
        model_count           = model_count + 1'b1;
    endtask

    task automatic drop_head();
        model_valid[model_rd] = 1'b0;
        model_rd              = model_rd + 1'b1;
        model_count           = model_count - 1'b1;
        pop_total++;
    endtask

    // ------------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------------

    task automatic check_scan();
        segments_t expected;
        expected = expected_segments(digit);
        assert (abcdefgh === expected) else
        begin
            display_errors++;
            $display("Error: abcdefgh = %h, expected %h on digit %h", abcdefgh, expected, digit);
        end
        if (digit !== last_digit)
        begin
            // scan moves one digit up and wraps after digit 7
            assert (digit === {last_digit[6:0], last_digit[7]}) else
            begin
                scan_errors++;
                $display("Error: digit = %h, expected %h", digit,
                         {last_digit[6:0], last_digit[7]});
            end
            if (scan_locked)
            begin
                assert (held == scan_period) else
                begin
                    scan_errors++;
                    $display("digit %h stayed active for %0d cycles instead of %0d",
                             last_digit, held, scan_period);
                end
            end
            scan_locked = 1'b1;
            held        = 1;
        end
        else
        begin
            held++;
        end
        last_digit = digit;
    endtask

    // infer push, pop or both from the step of the count and the head
    task automatic follow_led();
        fifo_count_t new_count;
        fifo_data_t  new_head;
        bit          step_ok;
        new_count = led[3:0];
        new_head  = led[7:4];
        step_ok   = (new_count == model_count)
                  || (new_count == model_count + 1'b1)
                  || (model_count != 4'd0 && new_count == model_count - 1'b1);
        assert (step_ok && new_count <= fifo_count_t'(fifo_depth)) else
        begin
            led_errors++;
            $display("Error: led[3:0] = %h, expected %h or one step from it",
                     new_count, model_count);
        end
        if (new_count == model_count + 1'b1)
            store_entry();
        else if (model_count != 4'd0 && new_count == model_count - 1'b1)
            drop_head();
        else if (new_count == model_count && model_count != 4'd0 && new_head !== last_head)
        begin
            drop_head();
            store_entry();
        end
        last_head = new_head;
    endtask

    task automatic check_led();
        logic [7:0] expected;
        expected = {model_data[model_rd], model_count};
        // head data is stale while empty
        if (model_count == 4'd0)
            expected[7:4] = led[7:4];
        assert (led === expected) else
        begin
            led_errors++;
            $display("Error: led = %h, expected %h", led, expected);
        end
    endtask

    // outputs are stable half a period after the edge
    always @(negedge clk)
    begin
        if (checking)
        begin
            check_scan();
            follow_led();
            check_led();
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic drive_keys(input logic [1:0] value);
        @(posedge clk);
        #1;
        key = value;
    endtask

    task automatic wait_count_change(output bit changed);
        fifo_count_t start;
        int          cycles;
        start   = led[3:0];
        changed = 1'b0;
        cycles  = 0;
        while (!changed && cycles < 4 * tick_period)
        begin
            @(negedge clk);
            cycles++;
            if (led[3:0] !== start)
                changed = 1'b1;
        end
        if (!changed)
        begin
            timeout_errors++;
            $display("Timeout: count on led stayed at %h for %0d cycles", start, cycles);
        end
    endtask

    task automatic press_until(input logic [1:0] value, input fifo_count_t target);
        bit changed;
        int steps;
        drive_keys(value);
        changed = 1'b1;
        steps   = 0;
        while (led[3:0] !== target && changed && steps < 2 * fifo_depth + 2)
        begin
            wait_count_change(changed);
            steps++;
        end
        drive_keys(2'b00);
    endtask

    task automatic hold_ticks(input logic [1:0] value, input int ticks);
        drive_keys(value);
        repeat (ticks * tick_period) @(posedge clk);
        drive_keys(2'b00);
        // a late tick may still act while the synchronizer drains
        repeat (3) @(posedge clk);
    endtask

    task automatic wait_for_digit(input slot_mask_t target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (digit !== target && cycles < 2 * fifo_depth * scan_period)
        begin
            @(negedge clk);
            cycles++;
        end
        if (digit !== target)
        begin
            timeout_errors++;
            $display("Timeout: digit %h never came up in the scan", target);
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        int          hold;
        int          ticks_done;
        int          pops_before;
        int          assertion_errors;
        seed           = 32'hc292_4890;
        clk            = 1'b0;
        reset          = 1'b1;
        key            = 2'b00;
        checking       = 1'b0;
        display_errors = 0;
        scan_errors    = 0;
        led_errors     = 0;
        timeout_errors = 0;
        pop_total      = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        clear_model();
        checking = 1'b1;

        // empty display over two full scans
        repeat (2 * fifo_depth * scan_period) @(posedge clk);
        assert (led === 8'h00) else
        begin
            led_errors++;
            $display("Error: led = %h, expected 00 after reset", led);
        end

        // fill so the first entry 2 stays at the head
        press_until(2'b10, 4'd8);
        assert (led === 8'h28) else
        begin
            led_errors++;
            $display("Error: led = %h, expected 28 when full", led);
        end

        // pushes while full are dropped and the index holds
        hold_ticks(2'b10, 4);
        press_until(2'b01, 4'd7);
        press_until(2'b10, 4'd8);
        // slot 0 sits on digit 7 and holds the ninth entry without a pointer dot
        wait_for_digit(8'h80);
        assert (abcdefgh === 8'b0110_0000) else
        begin
            display_errors++;
            $display("Error: abcdefgh = %h, expected 60 for slot 0", abcdefgh);
        end

        // drain, then check that pops on an empty FIFO are dropped
        press_until(2'b01, 4'd0);
        hold_ticks(2'b01, 3);
        assert (led[3:0] === 4'h0) else
        begin
            led_errors++;
            $display("Error: led[3:0] = %h, expected 0 after draining", led[3:0]);
        end

        // both keys hold the count while the pointers wrap past slot 7
        press_until(2'b10, 4'd3);
        pops_before = pop_total;
        hold_ticks(2'b11, 10);
        assert (led[3:0] === 4'h3) else
        begin
            led_errors++;
            $display("Error: led[3:0] = %h, expected 3 after holding both keys", led[3:0]);
        end
        assert (pop_total - pops_before >= 8) else
        begin
            led_errors++;
            $display("both keys moved the head only %0d times in ten ticks",
                     pop_total - pops_before);
        end

        // random key holds of one to eight ticks
        ticks_done = 0;
        while (ticks_done < 200)
        begin
            rnd  = $random(seed);
            hold = 1 + int'(rnd[4:2]);
            hold_ticks(rnd[1:0], hold);
            ticks_done += hold;
        end

        checking = 1'b0;
        assertion_errors = i_fifo_display_top.i_debug_fifo.i_fifo_sva.failures
                         + i_fifo_display_top.i_seven_segment_mux.i_scan_sva.failures;
        $display("errors: display %0d, scan %0d, led %0d, timeouts %0d, assertions %0d",
                 display_errors, scan_errors, led_errors, timeout_errors, assertion_errors);
        if (display_errors + scan_errors + led_errors + timeout_errors
            + assertion_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- testbench/fifo_display_sva.sv
// bound once to the FIFO and once to the display; scan_side picks which group of checks is live
module fifo_display_sva
    import fifo_demo_pkg::*;
#(
    parameter bit scan_side = 1'b0
)
(
    input              clk,
    input              reset,
    input              empty,
    input              full,
    input fifo_count_t count,
    input slot_mask_t  digit
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed checks, read by the testbench at the end of the run
    int failures = 0;

    generate
        if (scan_side)
        begin : g_scan
            // exactly one digit active
            digit_one_hot: assert property (@(posedge clk) disable iff (reset)
                $onehot(digit))
                else
                begin
                    failures++;
                    $error("digit %h is not one-hot", digit);
                end
        end
        else
        begin : g_fifo
            // flags come from one count, never both
            flags_exclusive: assert property (@(posedge clk) disable iff (reset)
                !(empty && full))
                else
                begin
                    failures++;
                    $error("empty and full are both high");
                end

            count_in_range: assert property (@(posedge clk) disable iff (reset)
                count <= fifo_count_t'(fifo_depth))
                else
                begin
                    failures++;
                    $error("count %h is above the depth", count);
                end

            // wide compare, so 0 to 15 is a jump
            count_step: assert property (@(posedge clk) disable iff (reset)
                (int'(count) <= int'($past(count)) + 1)
                && (int'(count) + 1 >= int'($past(count))))
                else
                begin
                    failures++;
                    $error("count moved from %h to %h in one cycle", $past(count), count);
                end
        end
    endgenerate

endmodule

bind debug_fifo fifo_display_sva #(.scan_side (1'b0)) i_fifo_sva
(
    .clk   (clk),
    .reset (reset),
    .empty (empty),
    .full  (full),
    .count (count),
    .digit (8'h01)
);

bind seven_segment_mux fifo_display_sva #(.scan_side (1'b1)) i_scan_sva
(
    .clk   (clk),
    .reset (reset),
    .empty (1'b0),
    .full  (1'b0),
    .count (4'h0),
    .digit (digit)
);

//--- design/fifo_display_top.sv
// key 1 pushes and key 0 pops once per tick; led shows head in [7:4] and count in [3:0]
module fifo_display_top
    import fifo_demo_pkg::*;
(
    input              clk,
    input              reset,
    input        [1:0] key,
    output logic [7:0] led,
    output segments_t  abcdefgh,
    output slot_mask_t digit
);

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------

    logic        tick;
    logic        push;
    logic        pop;
    logic        empty;
    logic        full;
    fifo_data_t  write_data;
    fifo_data_t  head_data;
    fifo_count_t count;

    // slot view from the FIFO to the display
    fifo_debug_if dbg ();

    // ----------------------------------------------------------------------
    // control chain
    // ----------------------------------------------------------------------

    // slow strobe replaces a divided clock
    tick_gen #(.period (tick_period)) i_tick_gen
    (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    key_sampler i_key_sampler
    (
        .clk   (clk),
        .reset (reset),
        .key   (key),
        .tick  (tick),
        .empty (empty),
        .full  (full),
        .push  (push),
        .pop   (pop)
    );

    pattern_source i_pattern_source
    (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .write_data (write_data)
    );

    // ----------------------------------------------------------------------
    // storage and display
    // ----------------------------------------------------------------------

    debug_fifo i_debug_fifo
    (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (pop),
        .write_data (write_data),
        .empty      (empty),
        .full       (full),
        .count      (count),
        .head_data  (head_data),
        .dbg        (dbg)
    );

    seven_segment_mux i_seven_segment_mux
    (
        .clk      (clk),
        .reset    (reset),
        .dbg      (dbg),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    assign led = {head_data, count};

endmodule

//--- design/seven_segment_mux.sv
// scanned display, active-high segments and one-hot digit; digit 0 shows the last slot
module seven_segment_mux
    import fifo_demo_pkg::*;
(
    input                       clk,
    input                       reset,
    fifo_debug_if.display_side  dbg,
    output segments_t           abcdefgh,
    output slot_mask_t          digit
);

    typedef logic [$clog2(scan_period) - 1:0] scan_count_t;

    // cycles spent on the current digit
    scan_count_t scan_cnt;
    // index of the active digit
    fifo_ptr_t   digit_idx;
    // digit index for the coming cycle
    fifo_ptr_t   next_idx;
    // slot mirrored onto that digit
    fifo_ptr_t   next_slot;
    segments_t   next_glyph;
    logic        next_dot;

    // ----------------------------------------------------------------------
    // hex decoder, abcdefgh with the dot left dark
    // ----------------------------------------------------------------------

    function automatic segments_t hex_glyph(input fifo_data_t value);
        case (value)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1110_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            4'hf: return 8'b1000_1110;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // scan sequencing
    // ----------------------------------------------------------------------

    always_comb
    begin
        // restart the scan from digit 0
        if (reset)
            next_idx = '0;
        else if (scan_cnt == scan_count_t'(scan_period - 1))
            next_idx = digit_idx + 1'b1;
        else
            next_idx = digit_idx;

        // slot 0 lands on the rightmost digit
        next_slot = fifo_ptr_t'(fifo_depth - 1) - next_idx;

        if (dbg.slot_valid[next_slot])
            next_glyph = hex_glyph(dbg.slot_data[next_slot]);
        else
            next_glyph = empty_slot_glyph;

        // dot marks either pointer
        next_dot = (next_slot == dbg.wr_ptr) | (next_slot == dbg.rd_ptr);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end
        else
        begin
            if (scan_cnt == scan_count_t'(scan_period - 1))
                scan_cnt <= '0;
            else
                scan_cnt <= scan_cnt + 1'b1;

            digit_idx <= next_idx;
        end
    end

    // digit and its segments update on the same edge
    always_ff @(posedge clk)
    begin
        digit    <= slot_mask_t'(1) << next_idx;
        abcdefgh <= (next_glyph & ~segment_dot) | (next_dot ? segment_dot : '0);
    end

endmodule

//--- design/debug_fifo.sv
// flip-flop FIFO with debug view; push while full and pop while empty are ignored
module debug_fifo
    import fifo_demo_pkg::*;
(
    input                    clk,
    input                    reset,
    input                    push,
    input                    pop,
    input  fifo_data_t       write_data,
    output logic             empty,
    output logic             full,
    output fifo_count_t      count,
    output fifo_data_t       head_data,
    fifo_debug_if.fifo_side  dbg
);

    // ----------------------------------------------------------------------
    // storage and pointers
    // ----------------------------------------------------------------------

    // payload slots
    fifo_data_t [fifo_depth - 1:0] slot_data;
    // live flag per slot
    slot_mask_t                    slot_valid;

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t occupancy;

    // requests that actually take effect
    logic push_ok;
    logic pop_ok;

    assign push_ok = push & ~full;
    assign pop_ok  = pop  & ~empty;

    // payload cleared by reset so the head reads 0 at start
    always_ff @(posedge clk)
    begin
        if (reset)
            slot_data <= '0;
        else if (push_ok)
            slot_data[wr_ptr] <= write_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot_valid <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occupancy  <= '0;
        end
        else
        begin
            // pop frees its slot before push marks its own
            if (pop_ok)
            begin
                slot_valid[rd_ptr] <= 1'b0;
                rd_ptr             <= rd_ptr + 1'b1;
            end

            if (push_ok)
            begin
                slot_valid[wr_ptr] <= 1'b1;
                wr_ptr             <= wr_ptr + 1'b1;
            end

            // count moves only when exactly one side acts
            case ({push_ok, pop_ok})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // status and debug view
    // ----------------------------------------------------------------------

    assign empty     = (occupancy == '0);
    assign full      = (occupancy == fifo_count_t'(fifo_depth));
    assign count     = occupancy;
    // data of the head slot goes stale once the FIFO empties
    assign head_data = slot_data[rd_ptr];

    assign dbg.slot_valid = slot_valid;
    assign dbg.slot_data  = slot_data;
    assign dbg.wr_ptr     = wr_ptr;
    assign dbg.rd_ptr     = rd_ptr;

endmodule

//--- design/pattern_source.sv
// walks the fixed pattern table; index moves only on an accepted push
module pattern_source
    import fifo_demo_pkg::*;
(
    input              clk,
    input              reset,
    input              push,
    output fifo_data_t write_data
);

    // position of the value the next push will store
    pattern_index_t index;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            index <= '0;
        end
        else if (push)
        begin
            // wraps naturally after pattern_length pushes
            index <= index + 1'b1;
        end
    end

    // table lookup, stable until the next push
    assign write_data = pattern_table[index];

endmodule

//--- design/key_sampler.sv
// keys are active high levels; push and pop are only issued on a tick and never overrun the FIFO
module key_sampler
(
    input              clk,
    input              reset,
    input        [1:0] key,
    input              tick,
    input              empty,
    input              full,
    output logic       push,
    output logic       pop
);

    // ----------------------------------------------------------------------
    // two-stage synchronizer
    // ----------------------------------------------------------------------

    // first stage may go metastable
    logic [1:0] key_meta;
    // second stage is safe to use
    logic [1:0] key_sync;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // ----------------------------------------------------------------------
    // request strobes
    // ----------------------------------------------------------------------

    // key 1 pushes, dropped when the FIFO is full
    assign push = tick & key_sync[1] & ~full;

    // key 0 pops, dropped when the FIFO is empty
    assign pop  = tick & key_sync[0] & ~empty;

endmodule

//--- design/tick_gen.sv
// one-cycle tick strobe every period clk cycles; period must be at least 2
module tick_gen
    import fifo_demo_pkg::*;
#(
    parameter int period = tick_period
)
(
    input        clk,
    input        reset,
    output logic tick
);

    typedef logic [$clog2(period) - 1:0] tick_count_t;

    // cycles left before the next strobe
    tick_count_t remaining;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= tick_count_t'(period - 1);
            tick      <= 1'b0;
        end
        else if (remaining == '0)
        begin
            // reload and pulse for exactly one cycle
            remaining <= tick_count_t'(period - 1);
            tick      <= 1'b1;
        end
        else
        begin
            remaining <= remaining - 1'b1;
            tick      <= 1'b0;
        end
    end

endmodule

//--- design/fifo_debug_if.sv
// per-slot FIFO view for the display; pointers are raw slot indices, not mirrored
interface fifo_debug_if
    import fifo_demo_pkg::*;
();

    // live flag of each slot
    slot_mask_t                    slot_valid;
    // stored digit of each slot, meaningful only where valid
    fifo_data_t [fifo_depth - 1:0] slot_data;
    // next slot to be written
    fifo_ptr_t                     wr_ptr;
    // slot holding the head entry
    fifo_ptr_t                     rd_ptr;

    // FIFO drives the view
    modport fifo_side
    (
        output slot_valid, slot_data, wr_ptr, rd_ptr
    );

    // display only reads it
    modport display_side
    (
        input slot_valid, slot_data, wr_ptr, rd_ptr
    );

endinterface

//--- design/fifo_demo_pkg.sv
// shared widths, timing and pattern constants; fifo_depth must be a power of two for the pointers
package fifo_demo_pkg;

    // ----------------------------------------------------------------------
    // sizes
    // ----------------------------------------------------------------------

    // one entry holds a single hex digit
    localparam int data_width  = 4;
    // one slot per display digit
    localparam int fifo_depth  = 8;
    localparam int ptr_width   = 3;
    // occupancy runs 0 to fifo_depth inclusive, so one extra bit
    localparam int count_width = 4;

    // short periods keep simulation fast, a board would use clk_mhz * 1e6
    localparam int tick_period = 16;
    // clk cycles each digit stays lit
    localparam int scan_period = 4;

    localparam int pattern_length      = 16;
    localparam int pattern_index_width = 4;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------

    typedef logic [data_width          - 1:0] fifo_data_t;
    typedef logic [ptr_width           - 1:0] fifo_ptr_t;
    typedef logic [count_width         - 1:0] fifo_count_t;
    typedef logic [pattern_index_width - 1:0] pattern_index_t;
    // one bit per slot, also one bit per digit
    typedef logic [fifo_depth          - 1:0] slot_mask_t;
    // segment order abcdefgh, bit 0 is the dot
    typedef logic [7:0]                       segments_t;

    // ----------------------------------------------------------------------
    // constants
    // ----------------------------------------------------------------------

    // values stored by successive pushes
    localparam fifo_data_t pattern_table [pattern_length] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // middle bar g only, shown for a free slot
    localparam segments_t empty_slot_glyph = 8'b0000_0010;
    localparam segments_t segment_dot      = 8'b0000_0001;

endpackage
